// ==== verilog/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and address width
`define XLEN 32

// Architectural registers
`define NUM_REGS 32

// Width of a register number
`define REG_AW 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== verilog/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

    // Major opcodes, encoded as the instruction opcode field
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_sel_e wb_sel;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  rs1_data;
        logic [`XLEN-1:0]  rs2_data;
        logic [`XLEN-1:0]  imm;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
    } idex_t;

    typedef struct packed {
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
        wb_sel_e            wb_sel;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   store_data;
        logic [`XLEN-1:0]   pc4;
        logic [`REG_AW-1:0] rd;
    } exmem_t;

    typedef struct packed {
        logic               reg_write;
        wb_sel_e            wb_sel;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   load_data;
        logic [`XLEN-1:0]   pc4;
        logic [`REG_AW-1:0] rd;
    } memwb_t;

endpackage

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_unit (
    input  logic [`XLEN-1:0]   instr,
    output cpu_pkg::ctrl_t     ctrl,
    output logic [`XLEN-1:0]   imm,
    output logic [`REG_AW-1:0] rs1,
    output logic [`REG_AW-1:0] rs2,
    output logic [`REG_AW-1:0] rd
);

    import cpu_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    // No destination unless the instruction writes back
    assign rd  = ctrl.reg_write ? instr[11:7] : '0;

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_ALU;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
                // Only SUB uses the alternate funct7
                if (funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'b000)) begin
                    ctrl = '0;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    ctrl.alu_op      = ALU_ADD;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    imm              = imm_i;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.alu_op      = ALU_ADD;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.wb_sel      = WB_MEM;
                    imm              = imm_i;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.alu_op      = ALU_ADD;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    imm              = imm_s;
                end
            end
            OPC_BRANCH: begin
                // BEQ and BNE only
                if (funct3[2:1] == 2'b00) begin
                    ctrl.alu_op    = ALU_SUB;
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    imm            = imm_b;
                end
            end
            OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm            = imm_j;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic [`REG_AW-1:0] rd_addr,
    input  logic [`XLEN-1:0]   rd_data,
    input  logic               we,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Writeback in the same cycle is seen by decode
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (we && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (we && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  cpu_pkg::alu_op_e op,
    output logic [`XLEN-1:0] result,
    output logic             equal
);

    import cpu_pkg::*;

    logic [`XLEN-1:0] diff;

    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // Signed compare
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    // Branch condition for BEQ and BNE
    assign equal = (diff == '0);

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module hazard_unit (
    input  logic               [`REG_AW-1:0] id_rs1,
    input  logic               [`REG_AW-1:0] id_rs2,
    input  logic               [`REG_AW-1:0] ex_rs1,
    input  logic               [`REG_AW-1:0] ex_rs2,
    input  logic               [`REG_AW-1:0] ex_rd,
    input  logic                             ex_mem_read,
    input  logic                             ex_redirect,
    input  logic               [`REG_AW-1:0] mem_rd,
    input  logic                             mem_reg_write,
    input  logic               [`REG_AW-1:0] wb_rd,
    input  logic                             wb_reg_write,
    input  logic                             im_stall,
    input  logic                             dm_stall,
    output logic                             pc_write,
    output logic                             ifid_write,
    output logic                             ifid_flush,
    output logic                             idex_flush,
    output logic                             freeze,
    output cpu_pkg::fwd_sel_e                fwd_a,
    output cpu_pkg::fwd_sel_e                fwd_b
);

    import cpu_pkg::*;

    logic load_use;

    // Memory stage wins over writeback, x0 is never forwarded
    function automatic fwd_sel_e fwd_pick(
        input logic [`REG_AW-1:0] rs,
        input logic [`REG_AW-1:0] m_rd,
        input logic               m_we,
        input logic [`REG_AW-1:0] w_rd,
        input logic               w_we
    );
        if (m_we && m_rd != '0 && m_rd == rs) begin
            return FWD_MEM;
        end else if (w_we && w_rd != '0 && w_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // Any memory wait state holds the whole pipe
    assign freeze = im_stall | dm_stall;

    assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign pc_write   = !freeze && (ex_redirect || !load_use);
    assign ifid_write = !freeze && !load_use;
    assign ifid_flush = !freeze && ex_redirect;
    assign idex_flush = !freeze && (ex_redirect || load_use);

    always_comb begin
        fwd_a = fwd_pick(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
        fwd_b = fwd_pick(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    end

endmodule

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core (
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] dm_addr,
    output logic [`XLEN-1:0] dm_wdata,
    output logic             dm_we,
    output logic             dm_re,
    input  logic [`XLEN-1:0] dm_rdata,
    input  logic             im_stall,
    input  logic             dm_stall
);

    import cpu_pkg::*;

    ifid_t  ifid_q;
    idex_t  idex_q;
    exmem_t exmem_q;
    memwb_t memwb_q;

    ctrl_t              id_ctrl;
    logic [`XLEN-1:0]   id_imm;
    logic [`REG_AW-1:0] id_rs1;
    logic [`REG_AW-1:0] id_rs2;
    logic [`REG_AW-1:0] id_rd;
    logic [`XLEN-1:0]   id_rs1_data;
    logic [`XLEN-1:0]   id_rs2_data;

    logic     pc_write;
    logic     ifid_write;
    logic     ifid_flush;
    logic     idex_flush;
    logic     freeze;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    logic [`XLEN-1:0] ex_op_a;
    logic [`XLEN-1:0] ex_rs2_fwd;
    logic [`XLEN-1:0] ex_op_b;
    logic [`XLEN-1:0] ex_alu_result;
    logic [`XLEN-1:0] ex_target;
    logic [`XLEN-1:0] ex_pc4;
    logic             ex_equal;
    logic             ex_redirect;

    logic             store_done;
    logic [`XLEN-1:0] mem_fwd_data;
    logic [`XLEN-1:0] wb_data;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (pc_write) begin
            pc <= ex_redirect ? ex_target : pc + `XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || ifid_flush) begin
            ifid_q <= '0;
        end else if (ifid_write) begin
            ifid_q <= '{pc: pc, instr: instr};
        end
    end

    // Decode
    decode_unit u_decode (
        .instr (ifid_q.instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm),
        .rs1   (id_rs1),
        .rs2   (id_rs2),
        .rd    (id_rd)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (id_rs1),
        .rs2_addr (id_rs2),
        .rd_addr  (memwb_q.rd),
        .rd_data  (wb_data),
        .we       (memwb_q.reg_write),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || idex_flush) begin
            idex_q <= '0;
        end else if (!freeze) begin
            idex_q <= '{ctrl: id_ctrl, pc: ifid_q.pc, rs1_data: id_rs1_data,
                        rs2_data: id_rs2_data, imm: id_imm, rs1: id_rs1,
                        rs2: id_rs2, rd: id_rd};
        end
    end

    hazard_unit u_hazard (
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .ex_rs1        (idex_q.rs1),
        .ex_rs2        (idex_q.rs2),
        .ex_rd         (idex_q.rd),
        .ex_mem_read   (idex_q.ctrl.mem_read),
        .ex_redirect   (ex_redirect),
        .mem_rd        (exmem_q.rd),
        .mem_reg_write (exmem_q.reg_write),
        .wb_rd         (memwb_q.rd),
        .wb_reg_write  (memwb_q.reg_write),
        .im_stall      (im_stall),
        .dm_stall      (dm_stall),
        .pc_write      (pc_write),
        .ifid_write    (ifid_write),
        .ifid_flush    (ifid_flush),
        .idex_flush    (idex_flush),
        .freeze        (freeze),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    // Execute
    always_comb begin
        ex_op_a    = fwd_mux(fwd_a, idex_q.rs1_data, mem_fwd_data, wb_data);
        ex_rs2_fwd = fwd_mux(fwd_b, idex_q.rs2_data, mem_fwd_data, wb_data);
    end

    assign ex_op_b = idex_q.ctrl.alu_src_imm ? idex_q.imm : ex_rs2_fwd;

    alu u_alu (
        .a      (ex_op_a),
        .b      (ex_op_b),
        .op     (idex_q.ctrl.alu_op),
        .result (ex_alu_result),
        .equal  (ex_equal)
    );

    assign ex_target   = idex_q.pc + idex_q.imm;
    assign ex_pc4      = idex_q.pc + `XLEN'(4);
    assign ex_redirect = idex_q.ctrl.jump ||
                         (idex_q.ctrl.branch && (ex_equal != idex_q.ctrl.branch_ne));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exmem_q <= '0;
        end else if (!freeze) begin
            exmem_q <= '{mem_read: idex_q.ctrl.mem_read, mem_write: idex_q.ctrl.mem_write,
                         reg_write: idex_q.ctrl.reg_write, wb_sel: idex_q.ctrl.wb_sel,
                         alu_result: ex_alu_result, store_data: ex_rs2_fwd,
                         pc4: ex_pc4, rd: idex_q.rd};
        end
    end

    // Memory
    // A store taken during a fetch wait is not repeated while frozen
    always_ff @(posedge clk) begin
        if (!rst_n || !freeze) begin
            store_done <= 1'b0;
        end else if (exmem_q.mem_write && !dm_stall) begin
            store_done <= 1'b1;
        end
    end

    assign dm_addr  = exmem_q.alu_result;
    assign dm_wdata = exmem_q.store_data;
    assign dm_we    = exmem_q.mem_write && !store_done;
    assign dm_re    = exmem_q.mem_read;

    // Loads never forward from here because the load-use bubble covers them
    assign mem_fwd_data = (exmem_q.wb_sel == WB_PC4) ? exmem_q.pc4 : exmem_q.alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memwb_q <= '0;
        end else if (!freeze) begin
            memwb_q <= '{reg_write: exmem_q.reg_write, wb_sel: exmem_q.wb_sel,
                         alu_result: exmem_q.alu_result, load_data: dm_rdata,
                         pc4: exmem_q.pc4, rd: exmem_q.rd};
        end
    end

    // Writeback
    always_comb begin
        case (memwb_q.wb_sel)
            WB_MEM:  wb_data = memwb_q.load_data;
            WB_PC4:  wb_data = memwb_q.pc4;
            default: wb_data = memwb_q.alu_result;
        endcase
    end

endmodule

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// R-type function codes as {funct7, funct3}
localparam logic [9:0] FN_ADD = {7'h00, 3'h0};
localparam logic [9:0] FN_SUB = {7'h20, 3'h0};
localparam logic [9:0] FN_SLT = {7'h00, 3'h2};
localparam logic [9:0] FN_XOR = {7'h00, 3'h4};
localparam logic [9:0] FN_OR  = {7'h00, 3'h6};
localparam logic [9:0] FN_AND = {7'h00, 3'h7};

task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
endtask

task automatic op_rr(input logic [9:0] fn, input int rd, input int rs1, input int rs2);
    emit({fn[9:3], rs2[4:0], rs1[4:0], fn[2:0], rd[4:0], 7'b0110011});
endtask

task automatic addi(input int rd, input int rs1, input int imm);
    emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011});
endtask

task automatic lw(input int rd, input int rs1, input int imm);
    emit({imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011});
endtask

task automatic sw(input int rs2, input int rs1, input int imm);
    emit({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011});
endtask

// ne selects BNE, otherwise BEQ
task automatic branch(input logic ne, input int rs1, input int rs2, input int off);
    emit({off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, off[4:1], off[11], 7'b1100011});
endtask

task automatic jal(input int rd, input int off);
    emit({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111});
endtask

// ISA model, appends the stores of one program to the expected trace
function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] pcm;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wr;
    int          steps;
    x = '{default: '0};
    mem = dmem;
    pcm = `RESET_PC;
    steps = 0;
    while (steps < 1000) begin
        ins = imem[pcm[9:2]];
        a = x[ins[19:15]];
        b = x[ins[24:20]];
        nxt = pcm + 32'd4;
        wr = 1'b0;
        res = '0;
        steps++;
        case (ins[6:0])
            7'b0110011: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'h0: res = ins[30] ? a - b : a + b;
                    3'h2: res = {31'b0, $signed(a) < $signed(b)};
                    3'h4: res = a ^ b;
                    3'h6: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0010011: begin
                wr = 1'b1;
                res = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'b0000011: begin
                wr = 1'b1;
                addr = a + {{20{ins[31]}}, ins[31:20]};
                res = mem[addr[9:2]];
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            7'b1100011: begin
                if ((a == b) != ins[12]) begin
                    nxt = pcm + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                wr = 1'b1;
                res = pcm + 32'd4;
                nxt = pcm + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        // A jump to itself ends the program
        if (nxt == pcm) begin
            return steps;
        end
        pcm = nxt;
    end
    return steps;
endfunction

`endif

// ==== verification/tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu_core;

    localparam int MEM_WORDS = 256;
    localparam int NUM_TESTS = 6;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] dm_addr;
    logic [`XLEN-1:0] dm_wdata;
    logic             dm_we;
    logic             dm_re;
    logic [`XLEN-1:0] dm_rdata;
    logic             im_stall;
    logic             dm_stall;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          prog_len;
    int          seen = 0;
    int          store_errors = 0;
    int          errors;
    integer      seed;
    logic        stall_en;
    string       names [3] = '{"forwarding", "load-use", "branch and jump"};

    `include "tb_ref_model.svh"

    cpu_core i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc       (pc),
        .instr    (instr),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .dm_re    (dm_re),
        .dm_rdata (dm_rdata),
        .im_stall (im_stall),
        .dm_stall (dm_stall)
    );

    assign instr    = imem[pc[9:2]];
    assign dm_rdata = dm_re ? dmem[dm_addr[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Independent wait states on the two memory ports
    always @(negedge clk) begin
        if (stall_en && rst_n) begin
            im_stall = ($random(seed) & 3) == 0;
            dm_stall = ($random(seed) & 3) == 0;
        end else begin
            im_stall = 1'b0;
            dm_stall = 1'b0;
        end
    end

    // Store commit and compare against the model trace
    always @(posedge clk) begin
        if (rst_n && dm_we && !dm_stall) begin
            if (seen >= exp_addr.size()) begin
                $display("Unexpected store at time %0t to %h with data %h", $time, dm_addr,
                         dm_wdata);
                store_errors++;
            end else begin
                if (dm_addr !== exp_addr[seen]) begin
                    $display("FAILED time=%0t dm_addr expected %h actual %h", $time,
                             exp_addr[seen], dm_addr);
                    store_errors++;
                end
                if (dm_wdata !== exp_data[seen]) begin
                    $display("FAILED time=%0t dm_wdata expected %h actual %h", $time,
                             exp_data[seen], dm_wdata);
                    store_errors++;
                end
            end
            dmem[dm_addr[9:2]] = dm_wdata;
            seen++;
        end
    end

    task automatic build_program(input int which);
        imem = '{default: '0};
        prog_len = 0;
        case (which)
            0: begin
                addi(1, 0, 5);
                addi(2, 1, 291);
                op_rr(FN_ADD, 3, 1, 2);
                op_rr(FN_SUB, 4, 3, 1);
                op_rr(FN_AND, 5, 4, 3);
                op_rr(FN_OR, 6, 5, 1);
                op_rr(FN_XOR, 7, 6, 2);
                op_rr(FN_SLT, 8, 4, 7);
                addi(9, 0, -3);
                op_rr(FN_SLT, 10, 9, 1);
                addi(12, 0, 64);
                sw(3, 12, 0);
                sw(4, 12, 4);
                sw(5, 12, 8);
                sw(6, 12, 12);
                sw(7, 12, 16);
                sw(8, 12, 20);
                sw(10, 12, 24);
                op_rr(FN_SUB, 11, 9, 7);
                sw(11, 0, 96);
                jal(0, 0);
            end
            1: begin
                lw(1, 0, 0);
                op_rr(FN_ADD, 2, 1, 1);
                sw(2, 0, 128);
                lw(3, 0, 4);
                sw(3, 0, 132);
                lw(4, 0, 128);
                addi(5, 4, 1);
                sw(5, 0, 136);
                lw(6, 0, 8);
                addi(7, 0, 3);
                op_rr(FN_ADD, 8, 6, 7);
                sw(8, 0, 140);
                jal(0, 0);
            end
            default: begin
                addi(1, 0, 1);
                addi(2, 0, 1);
                branch(1'b0, 1, 2, 12);
                addi(3, 0, 17);
                sw(3, 0, 192);
                branch(1'b1, 1, 2, 12);
                addi(4, 0, 34);
                sw(4, 0, 196);
                branch(1'b0, 1, 0, 12);
                addi(5, 0, 51);
                sw(5, 0, 200);
                branch(1'b1, 1, 0, 12);
                sw(1, 0, 204);
                sw(2, 0, 204);
                jal(6, 12);
                sw(1, 0, 208);
                sw(1, 0, 212);
                sw(6, 0, 216);
                // Countdown loop with a backward branch
                addi(7, 0, 3);
                addi(7, 7, -1);
                sw(7, 0, 220);
                branch(1'b1, 7, 0, -8);
                jal(0, 0);
            end
        endcase
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        if (pc !== `RESET_PC) begin
            $display("FAILED time=%0t pc expected %h actual %h", $time, `RESET_PC, pc);
            errors++;
        end
        if (dm_we !== 1'b0) begin
            $display("FAILED time=%0t dm_we expected 0 actual %b", $time, dm_we);
            errors++;
        end
        if (dm_re !== 1'b0) begin
            $display("FAILED time=%0t dm_re expected 0 actual %b", $time, dm_re);
            errors++;
        end
        rst_n = 1'b1;
    endtask

    initial begin
        int steps;
        int limit;
        int cycles;
        int first;
        int err_before;
        rst_n = 1'b0;
        im_stall = 1'b0;
        dm_stall = 1'b0;
        stall_en = 1'b0;
        seed = 32'h6cba_7b17;
        errors = 0;
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
        end
        // First pass without wait states, second pass with them
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors + store_errors;
            build_program(t % 3);
            stall_en = (t >= 3);
            first = exp_addr.size();
            steps = run_model();
            limit = 8 * steps + 200;
            apply_reset();
            cycles = 0;
            while (seen < exp_addr.size() && cycles < limit) begin
                @(negedge clk);
                cycles++;
            end
            if (seen < exp_addr.size()) begin
                $display("Timeout in test %0d: %0d of %0d stores seen after %0d cycles", t,
                         seen - first, exp_addr.size() - first, cycles);
                $display("Done: errors found");
                $finish;
            end
            // Idle in the final loop so a stray store shows up
            repeat (10) @(negedge clk);
            $display("test %0d %s, stalls %0b: %0d stores, %s", t, names[t % 3], stall_en,
                     exp_addr.size() - first,
                     (errors + store_errors == err_before) ? "clean" : "with errors");
        end
        $display("tests %0d, store errors %0d, other errors %0d", NUM_TESTS, store_errors,
                 errors);
        if (errors + store_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
+incdir+verification
verilog/cpu_pkg.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/cpu_core.sv
verification/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_cpu_core -f filelist.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_cpu_core | tee /dev/stderr | grep -qx "Done: no errors" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
